/* verilog.f */
+incdir+source
source/vdc_pkg.sv
source/vram_req_if.sv
source/bus_regs.sv
source/vram_arb.sv
source/video_timing.sv
source/pixel_out.sv
source/vdc_main.sv
tb/tb_vdc_main.sv

/* Bender.yml */
package:
  name: vdc

sources:
  - include_dirs:
      - source
    files:
      - source/vdc_pkg.sv
      - source/vram_req_if.sv
      - source/bus_regs.sv
      - source/vram_arb.sv
      - source/video_timing.sv
      - source/pixel_out.sv
      - source/vdc_main.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - tb/tb_vdc_main.sv

/* tb/tb_vdc_main.sv */
////////////////////
// video controller testbench
// bus tasks, VRAM/palette model, raster,
// pixel and interrupt checks
////////////////////
`default_nettype none
`timescale 1ns/10ps

`include "vdc_params.svh"

module tb_vdc_main;

logic           clk = 1'b0;
logic           reset_i;
logic           bus_cs_i;
logic           bus_wr_i;
logic [2:0]     bus_reg_num_i;
logic           bus_bytesel_i;
logic [7:0]     bus_data_i;
logic [7:0]     bus_data_o;
logic           bus_intr_o;
logic [3:0]     red_o;
logic [3:0]     green_o;
logic [3:0]     blue_o;
logic           hsync_o;
logic           vsync_o;
logic           dv_de_o;

logic [15:0]    vram_m [0:255];     // model VRAM
logic [11:0]    pal_m  [0:15];      // model palette
logic [15:0]    lfsr_q = 16'd9637;
int             cur_addr;
int             err_cnt = 0;
int             intr_cnt = 0;
int             intr_base;
bit             pix_check_en = 1'b0;
int             x;                  // monitor state
int             y;
int             hs_run;
int             frame_cyc;
bit             vs_prev;
bit             vs_seen;
logic [15:0]    word;
logic [7:0]     st;

vdc_main u_vdc_main (.*);

always #20 clk = ~clk;              // 40 ns period

task automatic fail_now(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first error");
endtask

task automatic check_eq(input string name, input int exp, input int act);
    assert (exp == act) else fail_now($sformatf("MISMATCH %s expected %0h actual %0h",
                                                name, exp, act));
endtask

// fibonacci with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);     // one step per bit
        v      = {v[14:0], lfsr_q[0]};
    end
endtask

// all bus tasks start and end on a falling edge
task automatic bus_write(input vdc_pkg::reg_num_e r, input logic odd, input logic [7:0] d);
    bus_cs_i      = 1'b1;
    bus_wr_i      = 1'b1;
    bus_reg_num_i = r;
    bus_bytesel_i = odd;
    bus_data_i    = d;
    @(negedge clk);
    bus_cs_i      = 1'b0;
    bus_wr_i      = 1'b0;
endtask

task automatic bus_read(input vdc_pkg::reg_num_e r, input logic odd, output logic [7:0] d);
    bus_reg_num_i = r;
    bus_bytesel_i = odd;
    #10 d = bus_data_o;                 // sampled mid low phase once the comb path settles
    @(negedge clk);
endtask

task automatic read_status(output logic [7:0] s);
    bus_read(vdc_pkg::REG_STATUS, 1'b0, s);
    assert (s[7:5] <= `VDC_CREDITS) else fail_now($sformatf(
        "MISMATCH credits_max expected <= %0d actual %0d", `VDC_CREDITS, s[7:5]));
endtask

task automatic wait_credits(input int need);
    logic [7:0] s;
    int         tries;
    tries = 0;
    read_status(s);
    while (int'(s[7:5]) < need) begin
        tries++;
        if (tries > 50) fail_now("timeout, VRAM credits never came back");
        read_status(s);
    end
endtask

task automatic wait_read_valid();
    logic [7:0] s;
    int         tries;
    tries = 0;
    read_status(s);
    while (!s[4]) begin
        tries++;
        if (tries > 50) fail_now("timeout, VRAM read data never arrived");
        read_status(s);
    end
endtask

task automatic wait_frames(input int n);
    int seen;
    int guard;
    bit prev;
    seen  = 0;
    guard = 0;
    prev  = vsync_o;
    while (seen < n) begin
        @(negedge clk);
        guard++;
        if (guard > 200 * n) fail_now("timeout, no vsync from the raster");
        if (vsync_o && !prev) seen++;
        prev = vsync_o;
    end
endtask

task automatic set_addr(input int a);
    bus_write(vdc_pkg::REG_ADDR, 1'b0, 8'(a >> 8));
    bus_write(vdc_pkg::REG_ADDR, 1'b1, 8'(a));
    cur_addr = a;
endtask

task automatic write_word(input logic [15:0] w, input bit poll);
    if (poll) wait_credits(1);
    bus_write(vdc_pkg::REG_DATA, 1'b0, w[15:8]);
    bus_write(vdc_pkg::REG_DATA, 1'b1, w[7:0]);     // commits
    vram_m[cur_addr] = w;
    cur_addr++;
endtask

task automatic read_check();
    logic [7:0] hi;
    logic [7:0] lo;
    wait_credits(1);
    bus_write(vdc_pkg::REG_RDATA, 1'b0, 8'h00);    // starts the read
    wait_read_valid();
    bus_read(vdc_pkg::REG_RDATA, 1'b0, hi);
    bus_read(vdc_pkg::REG_RDATA, 1'b1, lo);
    check_eq($sformatf("readback[%0d]", cur_addr), vram_m[cur_addr], {hi, lo});
    cur_addr++;
endtask

// raster and pixel monitor with x from de rise and y from vsync fall
always @(negedge clk) begin
    if (reset_i) begin
        x         = 0;
        y         = 0;
        hs_run    = 0;
        frame_cyc = 0;
        vs_prev   = 1'b0;
        vs_seen   = 1'b0;
    end else begin
        frame_cyc++;
        if (dv_de_o) begin
            if (pix_check_en) begin
                check_eq($sformatf("pixel y%0d x%0d", y, x),
                         pal_m[4'(vram_m[y * 2 + x / 4] >> (12 - 4 * (x % 4)))],
                         {red_o, green_o, blue_o});
            end
            x++;
        end else if (x != 0) begin
            check_eq("de_len", `VDC_H_VIS, x);
            x = 0;
            y++;
        end
        if (hsync_o) begin
            hs_run++;
        end else if (hs_run != 0) begin
            check_eq("hsync_len", `VDC_HSYNC_LEN, hs_run);
            hs_run = 0;
        end
        if (vsync_o && !vs_prev) begin
            if (vs_seen) check_eq("frame_len", `VDC_H_TOTAL * `VDC_V_TOTAL, frame_cyc);
            vs_seen   = 1'b1;
            frame_cyc = 0;
        end
        if (!vsync_o && vs_prev) y = 0;
        vs_prev = vsync_o;
        if (bus_intr_o) intr_cnt++;
    end
end

a_black_blank: assert property (@(posedge clk) disable iff (reset_i)
    !dv_de_o |-> {red_o, green_o, blue_o} == 12'h000)
    else fail_now("RGB was not black outside the display area");

a_intr_pulse: assert property (@(posedge clk) disable iff (reset_i)
    bus_intr_o |=> !bus_intr_o)
    else fail_now("interrupt output stayed high longer than one cycle");

initial begin
    reset_i       = 1'b1;
    bus_cs_i      = 1'b0;
    bus_wr_i      = 1'b0;
    bus_reg_num_i = 3'd0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;
    repeat (5) @(negedge clk);
    reset_i = 1'b0;

    read_status(st);
    check_eq("status_reset", {3'(`VDC_CREDITS), 5'b00000}, st);

    for (int i = 0; i < 16; i++) begin             // random palette
        take_bits(12, word);
        pal_m[i] = word[11:0];
        bus_write(vdc_pkg::REG_PAL, 1'b0, {4'(i), word[11:8]});
        bus_write(vdc_pkg::REG_PAL, 1'b1, word[7:0]);
    end

    set_addr(0);
    for (int i = 0; i < 14; i++) begin
        take_bits(16, word);
        write_word(word, 1'b1);
    end

    // two unpolled writes while the raster is fetching
    wait_credits(`VDC_CREDITS);
    for (int g = 0; !dv_de_o; g++) begin
        if (g > 200) fail_now("timeout, display enable never went high");
        @(negedge clk);
    end
    take_bits(16, word);
    write_word(word, 1'b0);
    take_bits(16, word);
    write_word(word, 1'b0);
    read_status(st);
    wait_credits(`VDC_CREDITS);                    // drains back to full

    wait_frames(1);
    pix_check_en = 1'b1;
    set_addr(0);
    for (int i = 0; i < 16; i++) read_check();
    wait_frames(2);

    // mask still 0 so status sets without a strobe
    check_eq("intr_masked", 0, intr_cnt);
    read_status(st);
    check_eq("intr_status_set", 1, st[0]);
    bus_write(vdc_pkg::REG_INTR_MASK, 1'b0, 8'h01);
    bus_write(vdc_pkg::REG_INTR_CLR, 1'b0, 8'h01);
    intr_base = intr_cnt;
    wait_frames(2);
    check_eq("intr_once", intr_base + 1, intr_cnt);
    wait_frames(2);
    check_eq("intr_held", intr_base + 1, intr_cnt);  // status still pending
    bus_write(vdc_pkg::REG_INTR_CLR, 1'b0, 8'h01);
    wait_frames(2);
    check_eq("intr_again", intr_base + 2, intr_cnt);

    if (err_cnt == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* source/vdc_main.sv */
////////////////////
// video controller top
// CPU bus, VRAM, raster, palette, interrupt
////////////////////
`default_nettype none
`timescale 1ns/10ps

module vdc_main (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_i,
    input  wire logic           bus_wr_i,
    input  wire logic [2:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,     // interrupt strobe
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

logic           vid_rd;
logic [7:0]     vid_addr;
logic [15:0]    vid_data;
logic           pal_wr;
logic [3:0]     pal_idx;
logic [11:0]    pal_rgb;
logic [3:0]     pix_idx;
logic           hsync;
logic           vsync;
logic           de;
logic           frame_start;
logic [3:0]     intr_mask;
logic [3:0]     intr_clear;
logic [3:0]     intr_status;    // pending, cleared by CPU
logic [3:0]     intr_signal;

assign intr_signal = {3'b000, frame_start};     // bit 0 = vblank

vram_req_if vram_if();

bus_regs u_bus_regs (
    .clk(clk), .reset_i(reset_i),
    .bus_cs_i(bus_cs_i), .bus_wr_i(bus_wr_i), .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .vram(vram_if.producer),
    .pal_wr_o(pal_wr), .pal_idx_o(pal_idx), .pal_rgb_o(pal_rgb),
    .intr_mask_o(intr_mask), .intr_clear_o(intr_clear), .intr_status_i(intr_status)
);

vram_arb u_vram_arb (
    .clk(clk), .reset_i(reset_i),
    .cpu(vram_if.consumer),
    .vid_rd_i(vid_rd), .vid_addr_i(vid_addr), .vid_data_o(vid_data)
);

video_timing u_video_timing (
    .clk(clk), .reset_i(reset_i),
    .vid_rd_o(vid_rd), .vid_addr_o(vid_addr), .vid_data_i(vid_data),
    .pix_idx_o(pix_idx), .hsync_o(hsync), .vsync_o(vsync), .de_o(de),
    .frame_start_o(frame_start)
);

pixel_out u_pixel_out (
    .clk(clk), .reset_i(reset_i),
    .pal_wr_i(pal_wr), .pal_idx_i(pal_idx), .pal_rgb_i(pal_rgb),
    .pix_idx_i(pix_idx), .hsync_i(hsync), .vsync_i(vsync), .de_i(de),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

// interrupt status and strobe
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        bus_intr_o  <= (intr_signal & intr_mask & ~intr_status) != 4'b0000;    // new, enabled
        intr_status <= (intr_status | intr_signal) & ~intr_clear;
    end
end

endmodule

`default_nettype wire

/* source/pixel_out.sv */
////////////////////
// pixel output
// palette lookup, black outside display
////////////////////
`default_nettype none
`timescale 1ns/10ps

module pixel_out (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           pal_wr_i,
    input  wire logic [3:0]     pal_idx_i,
    input  wire logic [11:0]    pal_rgb_i,      // {r, g, b}
    input  wire logic [3:0]     pix_idx_i,
    input  wire logic           hsync_i,
    input  wire logic           vsync_i,
    input  wire logic           de_i,
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

logic [11:0] pal_mem [0:15];    // 16 entries of 4:4:4

always_ff @(posedge clk) begin
    if (pal_wr_i) begin
        pal_mem[pal_idx_i] <= pal_rgb_i;
    end
end

// third lag stage, syncs ride along
always_ff @(posedge clk) begin
    if (reset_i) begin
        {red_o, green_o, blue_o} <= '0;
        hsync_o                  <= 1'b0;
        vsync_o                  <= 1'b0;
        dv_de_o                  <= 1'b0;
    end else begin
        {red_o, green_o, blue_o} <= de_i ? pal_mem[pix_idx_i] : 12'h000;
        hsync_o                  <= hsync_i;
        vsync_o                  <= vsync_i;
        dv_de_o                  <= de_i;
    end
end

endmodule

`default_nettype wire

/* source/video_timing.sv */
////////////////////
// raster timing
// h/v counters, syncs, VRAM fetch and
// nibble serializer, 2 cycles behind counters
////////////////////
`default_nettype none
`timescale 1ns/10ps

`include "vdc_params.svh"

module video_timing (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    output logic                            vid_rd_o,
    output logic      [`VDC_VRAM_AW-1:0]    vid_addr_o,
    input  wire logic [15:0]                vid_data_i,
    output logic      [3:0]                 pix_idx_o,
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            de_o,
    output logic                            frame_start_o   // first blank line
);

localparam int HW = $clog2(`VDC_H_TOTAL);
localparam int VW = $clog2(`VDC_V_TOTAL);

logic [HW-1:0]  h_q;
logic [VW-1:0]  v_q;
logic           h_vis;
logic           v_vis;
logic           hsync_c;
logic           vsync_c;
logic           ld_q;           // fetched word arrives this cycle
logic [15:0]    shift_q;
logic [2:0]     sync_d1_q;      // {hsync, vsync, de} stage 1

assign h_vis   = h_q < HW'(`VDC_H_VIS);
assign v_vis   = v_q < VW'(`VDC_V_VIS);
assign hsync_c = h_q >= HW'(`VDC_HSYNC_START)
              && h_q <  HW'(`VDC_HSYNC_START + `VDC_HSYNC_LEN);
assign vsync_c = v_q >= VW'(`VDC_VSYNC_START)
              && v_q <  VW'(`VDC_VSYNC_START + `VDC_VSYNC_LEN);

// one word per 4 visible pixels
assign vid_rd_o   = h_vis && v_vis && h_q[1:0] == 2'b00;
assign vid_addr_o = `VDC_VRAM_AW'(v_q) * `VDC_VRAM_AW'(`VDC_H_VIS / 4)
                  + `VDC_VRAM_AW'(h_q >> 2);
assign pix_idx_o  = shift_q[15:12];                     // msb nibble first

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_q           <= '0;
        v_q           <= '0;
        ld_q          <= 1'b0;
        sync_d1_q     <= '0;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        de_o          <= 1'b0;
        frame_start_o <= 1'b0;
    end else begin
        if (h_q == HW'(`VDC_H_TOTAL - 1)) begin
            h_q <= '0;
            v_q <= (v_q == VW'(`VDC_V_TOTAL - 1)) ? '0 : v_q + 1'b1;
        end else begin
            h_q <= h_q + 1'b1;
        end
        ld_q                        <= vid_rd_o;
        sync_d1_q                   <= {hsync_c, vsync_c, h_vis && v_vis};
        {hsync_o, vsync_o, de_o}    <= sync_d1_q;       // match serializer delay
        frame_start_o               <= v_q == VW'(`VDC_V_VIS) && h_q == '0;
    end
end

// serializer, data is don't-care outside de
always_ff @(posedge clk) begin
    if (ld_q) begin
        shift_q <= vid_data_i;
    end else begin
        shift_q <= {shift_q[11:0], 4'h0};
    end
end

endmodule

`default_nettype wire

/* source/vram_arb.sv */
////////////////////
// VRAM and arbiter
// video reads first, CPU requests queued
// and served in free slots
////////////////////
`default_nettype none
`timescale 1ns/10ps

`include "vdc_params.svh"

module vram_arb (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    vram_req_if.consumer                    cpu,
    input  wire logic                       vid_rd_i,
    input  wire logic [`VDC_VRAM_AW-1:0]    vid_addr_i,
    output logic      [15:0]                vid_data_o     // 1 cycle after vid_rd_i
);

localparam int DEPTH = `VDC_CREDITS;
localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW    = $clog2(DEPTH + 1);

logic [15:0]                mem [0:(1 << `VDC_VRAM_AW) - 1];
vdc_pkg::vram_op_e          fifo_op    [0:DEPTH-1];
logic [`VDC_VRAM_AW-1:0]    fifo_addr  [0:DEPTH-1];
logic [15:0]                fifo_wdata [0:DEPTH-1];
logic [PW-1:0]              wr_ptr_q;
logic [PW-1:0]              rd_ptr_q;
logic [CW-1:0]              count_q;
logic                       pop;        // head served this cycle
logic                       pop_wr;
logic                       pop_rd;

function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

assign pop            = !vid_rd_i && count_q != '0;     // video has absolute priority
assign pop_wr         = pop && fifo_op[rd_ptr_q] == vdc_pkg::OP_WRITE;
assign pop_rd         = pop && fifo_op[rd_ptr_q] == vdc_pkg::OP_READ;
assign cpu.credit_ret = pop;                            // entry frees as it is served

// FIFO pointers and read strobe
always_ff @(posedge clk) begin
    if (reset_i) begin
        wr_ptr_q        <= '0;
        rd_ptr_q        <= '0;
        count_q         <= '0;
        cpu.rdata_valid <= 1'b0;
    end else begin
        cpu.rdata_valid <= pop_rd;
        if (cpu.valid) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
        end
        if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
        end
        case ({cpu.valid, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: ;
        endcase
    end
end

// storage, one access per cycle
always_ff @(posedge clk) begin
    if (cpu.valid) begin
        fifo_op[wr_ptr_q]    <= cpu.op;
        fifo_addr[wr_ptr_q]  <= cpu.addr;
        fifo_wdata[wr_ptr_q] <= cpu.wdata;
    end
    if (vid_rd_i) begin
        vid_data_o <= mem[vid_addr_i];
    end
    if (pop_wr) begin
        mem[fifo_addr[rd_ptr_q]] <= fifo_wdata[rd_ptr_q];
    end
    if (pop_rd) begin
        cpu.rdata <= mem[fifo_addr[rd_ptr_q]];
    end
end

// credits upstream keep the queue from overflowing
a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
    cpu.valid |-> count_q < CW'(DEPTH));

endmodule

`default_nettype wire

/* source/bus_regs.sv */
////////////////////
// CPU register file
// byte bus decode, VRAM address and credits,
// palette writes and interrupt mask/clear
////////////////////
`default_nettype none
`timescale 1ns/10ps

`include "vdc_params.svh"

module bus_regs (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_i,
    input  wire logic           bus_wr_i,
    input  wire logic [2:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,      // 0 = even, 1 = odd byte
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    vram_req_if.producer        vram,
    output logic                pal_wr_o,
    output logic      [3:0]     pal_idx_o,
    output logic      [11:0]    pal_rgb_o,
    output logic      [3:0]     intr_mask_o,
    output logic      [3:0]     intr_clear_o,       // one cycle strobe
    input  wire logic [3:0]     intr_status_i
);

localparam int CW = $clog2(`VDC_CREDITS + 1);

vdc_pkg::reg_num_e  reg_num;
logic               bus_we;
logic               commit_wr;      // odd byte of DATA
logic               commit_rd;      // any write to RDATA
logic               take;           // request actually issued
logic [CW-1:0]      credits_q;
logic [15:0]        addr_q;         // only low bits reach VRAM
logic [7:0]         wdata_hi_q;
logic [15:0]        rdata_q;
logic               rd_valid_q;

assign bus_we    = bus_cs_i && bus_wr_i;
assign reg_num   = vdc_pkg::reg_num_e'(bus_reg_num_i);
assign commit_wr = bus_we && reg_num == vdc_pkg::REG_DATA && bus_bytesel_i;
assign commit_rd = bus_we && reg_num == vdc_pkg::REG_RDATA;
assign take      = (commit_wr || commit_rd) && credits_q != '0;   // dropped without a credit

// control state
always_ff @(posedge clk) begin
    if (reset_i) begin
        vram.valid   <= 1'b0;
        credits_q    <= CW'(`VDC_CREDITS);
        addr_q       <= '0;
        rd_valid_q   <= 1'b0;
        pal_wr_o     <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
    end else begin
        vram.valid   <= take;
        pal_wr_o     <= bus_we && reg_num == vdc_pkg::REG_PAL && bus_bytesel_i;
        intr_clear_o <= '0;
        case ({take, vram.credit_ret})
            2'b10:   credits_q <= credits_q - 1'b1;
            2'b01:   credits_q <= credits_q + 1'b1;
            default: ;                                  // both or none leave it
        endcase
        if (take) begin
            addr_q <= addr_q + 1'b1;                    // auto-increment
        end
        if (vram.rdata_valid) begin
            rd_valid_q <= 1'b1;
        end else if (take && commit_rd) begin
            rd_valid_q <= 1'b0;                         // new read pending
        end
        if (bus_we) begin
            case (reg_num)
                vdc_pkg::REG_ADDR: begin
                    if (bus_bytesel_i) begin
                        addr_q[7:0]  <= bus_data_i;
                    end else begin
                        addr_q[15:8] <= bus_data_i;
                    end
                end
                vdc_pkg::REG_INTR_MASK: intr_mask_o  <= bus_data_i[3:0];
                vdc_pkg::REG_INTR_CLR:  intr_clear_o <= bus_data_i[3:0];
                default: ;
            endcase
        end
    end
end

// request payload, palette staging, read data latch
always_ff @(posedge clk) begin
    if (take) begin
        vram.op    <= commit_wr ? vdc_pkg::OP_WRITE : vdc_pkg::OP_READ;
        vram.addr  <= addr_q[`VDC_VRAM_AW-1:0];
        vram.wdata <= {wdata_hi_q, bus_data_i};
    end
    if (bus_we && reg_num == vdc_pkg::REG_DATA && !bus_bytesel_i) begin
        wdata_hi_q <= bus_data_i;
    end
    if (bus_we && reg_num == vdc_pkg::REG_PAL) begin
        if (bus_bytesel_i) begin
            pal_rgb_o[7:0]  <= bus_data_i;              // green/blue
        end else begin
            pal_idx_o       <= bus_data_i[7:4];
            pal_rgb_o[11:8] <= bus_data_i[3:0];         // red
        end
    end
    if (vram.rdata_valid) begin
        rdata_q <= vram.rdata;
    end
end

// register readback
always_comb begin
    case (reg_num)
        vdc_pkg::REG_ADDR:      bus_data_o = bus_bytesel_i ? addr_q[7:0] : addr_q[15:8];
        vdc_pkg::REG_RDATA:     bus_data_o = bus_bytesel_i ? rdata_q[7:0] : rdata_q[15:8];
        vdc_pkg::REG_PAL:       bus_data_o = bus_bytesel_i ? pal_rgb_o[7:0]
                                                           : {pal_idx_o, pal_rgb_o[11:8]};
        vdc_pkg::REG_INTR_MASK: bus_data_o = {4'b0000, intr_mask_o};
        vdc_pkg::REG_STATUS:    bus_data_o = {3'(credits_q), rd_valid_q, intr_status_i};
        default:                bus_data_o = 8'h00;
    endcase
end

// a request in flight still holds its credit
a_valid_has_credit: assert property (@(posedge clk) disable iff (reset_i)
    vram.valid |-> credits_q < CW'(`VDC_CREDITS));

// returns never push the count past the FIFO depth
a_credit_max: assert property (@(posedge clk) disable iff (reset_i)
    credits_q <= CW'(`VDC_CREDITS));

endmodule

`default_nettype wire

/* source/vram_req_if.sv */
////////////////////
// CPU VRAM request link
// credit flow control, no ready
////////////////////
`default_nettype none
`timescale 1ns/10ps

`include "vdc_params.svh"

interface vram_req_if;

    logic                       valid;          // one request per high cycle
    vdc_pkg::vram_op_e          op;
    logic [`VDC_VRAM_AW-1:0]    addr;
    logic [15:0]                wdata;
    logic                       credit_ret;     // FIFO entry freed
    logic                       rdata_valid;    // read data this cycle
    logic [15:0]                rdata;

    // register side
    modport producer (
        output valid, op, addr, wdata,
        input  credit_ret, rdata_valid, rdata
    );

    // arbiter side
    modport consumer (
        input  valid, op, addr, wdata,
        output credit_ret, rdata_valid, rdata
    );

endinterface

`default_nettype wire

/* source/vdc_pkg.sv */
////////////////////
// video controller types
// register numbers and VRAM request opcodes
////////////////////
`default_nettype none

package vdc_pkg;

    // CPU register numbers on bus_reg_num_i
    typedef enum logic [2:0] {
        REG_ADDR      = 3'd0,   // even = addr high, odd = addr low
        REG_DATA      = 3'd1,   // odd byte commits the write
        REG_RDATA     = 3'd2,   // write starts a read
        REG_PAL       = 3'd3,   // even = index/red, odd = green/blue + commit
        REG_INTR_MASK = 3'd4,
        REG_INTR_CLR  = 3'd5,
        REG_STATUS    = 3'd6    // credits, read valid, intr status
    } reg_num_e;

    // CPU VRAM request kind
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } vram_op_e;

endpackage

`default_nettype wire

/* source/vdc_params.svh */
////////////////////
// video controller sizes
// raster geometry, VRAM depth and CPU request credits
////////////////////
`ifndef VDC_PARAMS_SVH
`define VDC_PARAMS_SVH

`define VDC_H_TOTAL      16     // pixels per line incl. blank
`define VDC_H_VIS        8      // visible pixels per line
`define VDC_V_TOTAL      8      // lines per frame incl. blank
`define VDC_V_VIS        4      // visible lines
`define VDC_HSYNC_START  10
`define VDC_HSYNC_LEN    2
`define VDC_VSYNC_START  5
`define VDC_VSYNC_LEN    1
`define VDC_VRAM_AW      8      // 256 x 16-bit words
`define VDC_CREDITS      2      // request FIFO depth, also credits at reset

`endif
